/* common/memFuncPkg.sv */
`default_nettype none

package memFuncPkg;

  localparam int WORD_BITS = 36;
  localparam int SECTION_BITS = 5;
  localparam int OFFSET_BITS = 18;

  // Microinstruction MEM field
  typedef enum logic [3:0] {
    NOP          = 4'd0,
    AREAD        = 4'd1,
    READ_AR      = 4'd2,
    READ_ARX     = 4'd3,
    WRITE        = 4'd4,
    RW_CYCLE     = 4'd5,
    RPW_CYCLE    = 4'd6,
    UNCOND_FETCH = 4'd7
  } memFuncT;

  typedef logic [2:0] dispatchT;

  typedef enum logic [1:0] {
    DEST_AR  = 2'd0,
    DEST_ARX = 2'd1,
    DEST_IR  = 2'd2
  } destT;

  typedef struct packed {
    logic [OFFSET_BITS-1:0] offset;
    logic doRead;
    logic doWrite;
    destT dest;
    logic [WORD_BITS-1:0] writeData;
  } cycleReqT;

  // AREAD cycle kind as {read, write, fetch}
  function automatic logic [2:0] dispatchCycle(input dispatchT dispatch);
    logic [2:0] kind;
    case (dispatch)
      3'd1: kind = 3'b101;
      3'd3: kind = 3'b010;
      3'd4, 3'd5: kind = 3'b100;
      3'd6, 3'd7: kind = 3'b110;
      default: kind = 3'b000;
    endcase
    return kind;
  endfunction

endpackage

`default_nettype wire

/* common/diagPkg.sv */
`default_nettype none

package diagPkg;

  typedef struct packed {
    logic [memFuncPkg::OFFSET_BITS-1:0] offset;
    logic doWrite;
    logic [memFuncPkg::WORD_BITS-1:0] writeData;
  } diagReqT;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Byte address, far above any memory size
  localparam logic [31:0] STATUS_ADDR = 32'h0010_0000;

endpackage

`default_nettype wire

/* mcl/memControl.sv */
`timescale 1ns/100ps
`default_nettype none

module memControl #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic uInstValid,
  input  wire memFuncPkg::memFuncT memFunc,
  input  wire memFuncPkg::dispatchT dispatch,
  input  wire logic [memFuncPkg::WORD_BITS-1:0] writeData,
  output logic uInstReady,
  input  wire logic adrErrNow,
  input  wire logic [memFuncPkg::OFFSET_BITS-1:0] effOffset,
  output logic cycleAccept,
  output logic cycleRead,
  output logic cycleWrite,
  output logic cycleFetch,
  output logic reqPush,
  output memFuncPkg::cycleReqT reqData,
  input  wire logic reqFull,
  input  wire logic respIn,
  input  wire logic [memFuncPkg::WORD_BITS-1:0] respWord,
  output logic respValid,
  output memFuncPkg::destT respDest,
  output logic [memFuncPkg::WORD_BITS-1:0] respData,
  output logic adrErr
);

  // Queued reads plus the one in the memory stage
  localparam int TAG_DEPTH = QUEUE_DEPTH + 1;
  localparam int PTR_BITS = $clog2(TAG_DEPTH);

  logic doRead;
  logic doWrite;
  logic doFetch;
  logic tagPush;
  memFuncPkg::destT cycleDest;
  memFuncPkg::destT tagMem [TAG_DEPTH];
  logic [PTR_BITS-1:0] tagWr;
  logic [PTR_BITS-1:0] tagRd;

  function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(TAG_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb begin
    doRead = 1'b0;
    doWrite = 1'b0;
    doFetch = 1'b0;
    case (memFunc)
      memFuncPkg::AREAD: {doRead, doWrite, doFetch} = memFuncPkg::dispatchCycle(dispatch);
      memFuncPkg::READ_AR, memFuncPkg::READ_ARX: doRead = 1'b1;
      memFuncPkg::WRITE: doWrite = 1'b1;
      // RPW has no pause here, same as RW
      memFuncPkg::RW_CYCLE, memFuncPkg::RPW_CYCLE: begin
        doRead = 1'b1;
        doWrite = 1'b1;
      end
      memFuncPkg::UNCOND_FETCH: begin
        doRead = 1'b1;
        doFetch = 1'b1;
      end
      default: ;
    endcase
    if (doFetch) begin
      cycleDest = memFuncPkg::DEST_IR;
    end else if (memFunc == memFuncPkg::READ_ARX) begin
      cycleDest = memFuncPkg::DEST_ARX;
    end else begin
      cycleDest = memFuncPkg::DEST_AR;
    end
  end

  assign uInstReady = ~reqFull;
  assign cycleAccept = uInstValid & uInstReady & (doRead | doWrite);
  assign cycleRead = doRead;
  assign cycleWrite = doWrite;
  assign cycleFetch = doFetch;

  // Bad address cycles never reach memory
  assign reqPush = cycleAccept & ~adrErrNow;
  assign tagPush = reqPush & doRead;
  assign reqData = '{offset: effOffset, doRead: doRead, doWrite: doWrite,
                     dest: cycleDest, writeData: writeData};

  always_ff @(posedge clk) begin
    if (tagPush) begin
      tagMem[tagWr] <= cycleDest;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tagWr <= '0;
      tagRd <= '0;
      adrErr <= 1'b0;
    end else begin
      adrErr <= cycleAccept & adrErrNow;
      if (tagPush) begin
        tagWr <= nextPtr(tagWr);
      end
      if (respIn) begin
        tagRd <= nextPtr(tagRd);
      end
    end
  end

  // Words come back in issue order
  assign respValid = respIn;
  assign respDest = tagMem[tagRd];
  assign respData = respWord;

endmodule

`default_nettype wire

/* mcl/vmaContext.sv */
`timescale 1ns/100ps
`default_nettype none

module vmaContext (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic [memFuncPkg::SECTION_BITS-1:0] vmaSection,
  input  wire logic [memFuncPkg::OFFSET_BITS-1:0] vmaOffset,
  input  wire logic userMode,
  input  wire logic publicMode,
  input  wire logic prevEnable,
  input  wire logic prevUser,
  input  wire logic [memFuncPkg::SECTION_BITS-1:0] prevSection,
  input  wire logic fmExtended,
  input  wire logic cycleAccept,
  input  wire logic cycleRead,
  input  wire logic cycleWrite,
  input  wire logic cycleFetch,
  output logic [memFuncPkg::OFFSET_BITS-1:0] effOffset,
  output logic adrErrNow,
  output logic [7:0] heldStatus
);

  logic usePrev;
  logic sectionNonZero;
  logic [memFuncPkg::SECTION_BITS-1:0] effSection;
  logic ctxUser;
  logic ctxPublic;
  logic ctxPrevious;
  logic ctxExtended;

  // Fetches always run in the current context
  assign usePrev = prevEnable & ~cycleFetch;
  assign effSection = usePrev ? prevSection : vmaSection;
  assign sectionNonZero = |effSection;
  assign effOffset = vmaOffset;

  assign ctxUser = usePrev ? prevUser : userMode;
  assign ctxPublic = publicMode;
  assign ctxPrevious = usePrev;
  assign ctxExtended = fmExtended & sectionNonZero;

  // Sections only exist with extended addressing
  assign adrErrNow = sectionNonZero & ~fmExtended;

  always_ff @(posedge clk) begin
    if (reset) begin
      heldStatus <= '0;
    end else if (cycleAccept) begin
      heldStatus <= {ctxUser, ctxPublic, ctxPrevious, ctxExtended,
                     cycleRead, cycleWrite, cycleFetch, adrErrNow};
    end
  end

endmodule

`default_nettype wire

/* src/reqQueue.sv */
`timescale 1ns/100ps
`default_nettype none

module reqQueue #(
  parameter type PAYLOAD = logic,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic push,
  input  wire PAYLOAD pushData,
  input  wire logic pop,
  output logic full,
  output logic empty,
  output PAYLOAD popData
);

  localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  PAYLOAD entries [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wrPtr;
  logic [PTR_BITS-1:0] rdPtr;
  logic [CNT_BITS-1:0] count;

  function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign full = count == CNT_BITS'(QUEUE_DEPTH);
  assign empty = count == '0;
  assign popData = entries[rdPtr];

  noPushWhenFull: assert property (@(posedge clk) disable iff (reset) !(push && full));
  noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

/* src/cycleArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module cycleArbiter #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic aEmpty,
  input  wire memFuncPkg::cycleReqT aData,
  input  wire logic bEmpty,
  input  wire diagPkg::diagReqT bData,
  output logic aPop,
  output logic bPop,
  output logic memEn,
  output logic memWe,
  output logic [ADDR_WIDTH-1:0] memAddr,
  output logic [memFuncPkg::WORD_BITS-1:0] memWdata,
  input  wire logic [memFuncPkg::WORD_BITS-1:0] memRdata,
  output logic aRespValid,
  output logic bRespValid,
  output logic [memFuncPkg::WORD_BITS-1:0] respWord
);

  logic lastB;

  // Microcode wins unless it went last and diag is waiting
  assign aPop = ~aEmpty & (bEmpty | lastB);
  assign bPop = ~bEmpty & ~aPop;
  assign memEn = aPop | bPop;

  always_comb begin
    if (aPop) begin
      memWe = aData.doWrite;
      memAddr = aData.offset[ADDR_WIDTH-1:0];
      memWdata = aData.writeData;
    end else begin
      memWe = bPop & bData.doWrite;
      memAddr = bData.offset[ADDR_WIDTH-1:0];
      memWdata = bData.writeData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lastB <= 1'b0;
      aRespValid <= 1'b0;
      bRespValid <= 1'b0;
    end else begin
      if (memEn) begin
        lastB <= bPop;
      end
      aRespValid <= aPop & aData.doRead;
      bRespValid <= bPop & ~bData.doWrite;
    end
  end

  assign respWord = memRdata;

  popsExclusive: assert property (@(posedge clk) disable iff (reset) !(aPop && bPop));

endmodule

`default_nettype wire

/* src/coreMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module coreMemory #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire logic clk,
  input  wire logic en,
  input  wire logic we,
  input  wire logic [ADDR_WIDTH-1:0] addr,
  input  wire logic [memFuncPkg::WORD_BITS-1:0] wdata,
  output logic [memFuncPkg::WORD_BITS-1:0] rdata
);

  logic [memFuncPkg::WORD_BITS-1:0] words [2**ADDR_WIDTH];

  // Old word comes out on a write
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= words[addr];
      if (we) begin
        words[addr] <= wdata;
      end
    end
  end

endmodule

`default_nettype wire

/* src/diagAxiPort.sv */
`timescale 1ns/100ps
`default_nettype none

module diagAxiPort #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic AWVALID,
  output logic AWREADY,
  input  wire logic [31:0] AWADDR,
  input  wire logic WVALID,
  output logic WREADY,
  input  wire logic [63:0] WDATA,
  output logic BVALID,
  input  wire logic BREADY,
  output logic [1:0] BRESP,
  input  wire logic ARVALID,
  output logic ARREADY,
  input  wire logic [31:0] ARADDR,
  output logic RVALID,
  input  wire logic RREADY,
  output logic [63:0] RDATA,
  output logic [1:0] RRESP,
  output logic reqPush,
  output diagPkg::diagReqT reqData,
  input  wire logic reqFull,
  input  wire logic respIn,
  input  wire logic [memFuncPkg::WORD_BITS-1:0] respWord,
  input  wire logic [7:0] heldStatus
);

  typedef enum logic [1:0] {IDLE, PUSH, WAIT_WORD, RESPOND} stateT;

  stateT state;
  logic readTake;
  logic writeTake;
  logic readStatus;
  logic readMem;
  logic writeMem;

  // Byte addresses, one 64-bit beat per word
  function automatic logic inMemory(input logic [31:0] addr);
    return (addr >> 3) < (32'd1 << ADDR_WIDTH);
  endfunction

  assign ARREADY = state == IDLE;
  // Reads go first; AW and W are expected together
  assign AWREADY = (state == IDLE) & ~ARVALID;
  assign WREADY = AWREADY;
  assign readTake = ARVALID & ARREADY;
  assign writeTake = AWVALID & WVALID & AWREADY;

  assign readStatus = ARADDR == diagPkg::STATUS_ADDR;
  assign readMem = inMemory(ARADDR);
  assign writeMem = inMemory(AWADDR);
  assign reqPush = (state == PUSH) & ~reqFull;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      BVALID <= 1'b0;
      RVALID <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (readTake) begin
            RVALID <= ~readMem;
            state <= readMem ? PUSH : RESPOND;
          end else if (writeTake) begin
            BVALID <= ~writeMem;
            state <= writeMem ? PUSH : RESPOND;
          end
        end
        PUSH: begin
          if (reqPush) begin
            BVALID <= reqData.doWrite;
            state <= reqData.doWrite ? RESPOND : WAIT_WORD;
          end
        end
        WAIT_WORD: begin
          if (respIn) begin
            RVALID <= 1'b1;
            state <= RESPOND;
          end
        end
        default: begin
          if ((RVALID && RREADY) || (BVALID && BREADY)) begin
            RVALID <= 1'b0;
            BVALID <= 1'b0;
            state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (readTake) begin
      reqData <= '{offset: ARADDR[3 +: memFuncPkg::OFFSET_BITS], doWrite: 1'b0,
                   writeData: '0};
      RDATA <= readStatus ? 64'(heldStatus) : '0;
      RRESP <= (readStatus || readMem) ? diagPkg::RESP_OKAY : diagPkg::RESP_SLVERR;
    end else if (writeTake) begin
      reqData <= '{offset: AWADDR[3 +: memFuncPkg::OFFSET_BITS], doWrite: 1'b1,
                   writeData: WDATA[memFuncPkg::WORD_BITS-1:0]};
      BRESP <= writeMem ? diagPkg::RESP_OKAY : diagPkg::RESP_SLVERR;
    end
    if (state == WAIT_WORD && respIn) begin
      RDATA <= 64'(respWord);
    end
  end

endmodule

`default_nettype wire

/* src/memSubsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module memSubsystem #(
  parameter int ADDR_WIDTH = 10,
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic uInstValid,
  output logic uInstReady,
  input  wire memFuncPkg::memFuncT memFunc,
  input  wire memFuncPkg::dispatchT dispatch,
  input  wire logic [memFuncPkg::WORD_BITS-1:0] writeData,
  input  wire logic [memFuncPkg::SECTION_BITS-1:0] vmaSection,
  input  wire logic [memFuncPkg::OFFSET_BITS-1:0] vmaOffset,
  input  wire logic userMode,
  input  wire logic publicMode,
  input  wire logic prevEnable,
  input  wire logic prevUser,
  input  wire logic [memFuncPkg::SECTION_BITS-1:0] prevSection,
  input  wire logic fmExtended,
  output logic respValid,
  output memFuncPkg::destT respDest,
  output logic [memFuncPkg::WORD_BITS-1:0] respData,
  output logic adrErr,
  input  wire logic AWVALID,
  output logic AWREADY,
  input  wire logic [31:0] AWADDR,
  input  wire logic WVALID,
  output logic WREADY,
  input  wire logic [63:0] WDATA,
  output logic BVALID,
  input  wire logic BREADY,
  output logic [1:0] BRESP,
  input  wire logic ARVALID,
  output logic ARREADY,
  input  wire logic [31:0] ARADDR,
  output logic RVALID,
  input  wire logic RREADY,
  output logic [63:0] RDATA,
  output logic [1:0] RRESP
);

  logic [memFuncPkg::OFFSET_BITS-1:0] effOffset;
  logic adrErrNow;
  logic cycleAccept;
  logic cycleRead;
  logic cycleWrite;
  logic cycleFetch;
  logic [7:0] heldStatus;
  logic aPush, aFull, aPop, aEmpty;
  logic bPush, bFull, bPop, bEmpty;
  memFuncPkg::cycleReqT aPushData, aData;
  diagPkg::diagReqT bPushData, bData;
  logic memEn, memWe;
  logic [ADDR_WIDTH-1:0] memAddr;
  logic [memFuncPkg::WORD_BITS-1:0] memWdata, memRdata, respWord;
  logic aRespValid, bRespValid;

  memControl #(.QUEUE_DEPTH(QUEUE_DEPTH)) mcl (
    .clk, .reset, .uInstValid, .memFunc, .dispatch, .writeData, .uInstReady,
    .adrErrNow, .effOffset, .cycleAccept, .cycleRead, .cycleWrite, .cycleFetch,
    .reqPush(aPush), .reqData(aPushData), .reqFull(aFull),
    .respIn(aRespValid), .respWord, .respValid, .respDest, .respData, .adrErr
  );

  vmaContext vma (
    .clk, .reset, .vmaSection, .vmaOffset, .userMode, .publicMode,
    .prevEnable, .prevUser, .prevSection, .fmExtended,
    .cycleAccept, .cycleRead, .cycleWrite, .cycleFetch,
    .effOffset, .adrErrNow, .heldStatus
  );

  reqQueue #(.PAYLOAD(memFuncPkg::cycleReqT), .QUEUE_DEPTH(QUEUE_DEPTH)) queueA (
    .clk, .reset, .push(aPush), .pushData(aPushData), .pop(aPop),
    .full(aFull), .empty(aEmpty), .popData(aData)
  );

  reqQueue #(.PAYLOAD(diagPkg::diagReqT), .QUEUE_DEPTH(QUEUE_DEPTH)) queueB (
    .clk, .reset, .push(bPush), .pushData(bPushData), .pop(bPop),
    .full(bFull), .empty(bEmpty), .popData(bData)
  );

  cycleArbiter #(.ADDR_WIDTH(ADDR_WIDTH)) arbiter (
    .clk, .reset, .aEmpty, .aData, .bEmpty, .bData, .aPop, .bPop,
    .memEn, .memWe, .memAddr, .memWdata, .memRdata,
    .aRespValid, .bRespValid, .respWord
  );

  coreMemory #(.ADDR_WIDTH(ADDR_WIDTH)) memory (
    .clk, .en(memEn), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
  );

  diagAxiPort #(.ADDR_WIDTH(ADDR_WIDTH)) diag (
    .clk, .reset, .AWVALID, .AWREADY, .AWADDR, .WVALID, .WREADY, .WDATA,
    .BVALID, .BREADY, .BRESP, .ARVALID, .ARREADY, .ARADDR,
    .RVALID, .RREADY, .RDATA, .RRESP,
    .reqPush(bPush), .reqData(bPushData), .reqFull(bFull),
    .respIn(bRespValid), .respWord, .heldStatus
  );

endmodule

`default_nettype wire

/* verif/memChecker.sv */
`timescale 1ns/100ps
`default_nettype none

module memChecker #(
  parameter int ADDR_WIDTH = 10
) (
  input  wire logic clk, reset, uInstValid, uInstReady,
  input  wire memFuncPkg::memFuncT memFunc,
  input  wire memFuncPkg::dispatchT dispatch,
  input  wire logic [35:0] writeData, respData,
  input  wire logic [4:0] vmaSection, prevSection,
  input  wire logic [17:0] vmaOffset,
  input  wire logic userMode, publicMode, prevEnable, prevUser, fmExtended,
  input  wire logic respValid, adrErr,
  input  wire memFuncPkg::destT respDest,
  input  wire logic AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY,
  input  wire logic ARVALID, ARREADY, RVALID, RREADY,
  input  wire logic [31:0] AWADDR, ARADDR,
  input  wire logic [63:0] WDATA, RDATA,
  input  wire logic [1:0] BRESP, RRESP, stepExpResp,
  input  wire logic stepExpErr,
  output int errorCount,
  output int pendingCount
);

  typedef struct packed {
    memFuncPkg::destT dest;
    logic [35:0] word;
  } respT;

  respT respQ[$];
  respT got;
  logic [35:0] refMem [2**ADDR_WIDTH];
  logic [7:0] statusModel;
  logic errNext;
  logic [63:0] expRdata;
  logic [1:0] expRresp;
  logic [1:0] expBresp;
  logic rd, wr, fe, usePrev;
  logic [4:0] sect;
  memFuncPkg::destT dest;

  function automatic logic inRange(input logic [31:0] addr);
    return (addr >> 3) < (32'd1 << ADDR_WIDTH);
  endfunction

  task automatic reportMismatch(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
    $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
    errorCount++;
  endtask

  // Sampled mid-cycle, where every handshake is stable
  always @(negedge clk) begin
    if (reset) begin
      errorCount = 0;
      statusModel = '0;
      errNext = 1'b0;
      respQ.delete();
    end else begin
      if (adrErr !== errNext) begin
        reportMismatch("adrErr", 64'(errNext), 64'(adrErr));
      end
      errNext = 1'b0;

      if (ARVALID && ARREADY) begin
        if (ARADDR == diagPkg::STATUS_ADDR) begin
          expRdata = 64'(statusModel);
        end else if (inRange(ARADDR)) begin
          expRdata = 64'(refMem[ARADDR[3 +: ADDR_WIDTH]]);
        end else begin
          expRdata = '0;
        end
        expRresp = stepExpResp;
      end
      if (RVALID && RREADY) begin
        if (RDATA !== expRdata) reportMismatch("RDATA", expRdata, RDATA);
        if (RRESP !== expRresp) reportMismatch("RRESP", 64'(expRresp), 64'(RRESP));
      end

      // Address and data channels are taken together
      if (AWVALID && WVALID && WREADY !== AWREADY) begin
        reportMismatch("WREADY", 64'(AWREADY), 64'(WREADY));
      end
      if (AWVALID && WVALID && AWREADY && WREADY) begin
        if (inRange(AWADDR)) begin
          refMem[AWADDR[3 +: ADDR_WIDTH]] = WDATA[35:0];
        end
        expBresp = stepExpResp;
      end
      if (BVALID && BREADY && BRESP !== expBresp) begin
        reportMismatch("BRESP", 64'(expBresp), 64'(BRESP));
      end

      if (respValid) begin
        if (respQ.size() == 0) begin
          $display("Microcode response at %0t with no read outstanding", $time);
          errorCount++;
        end else begin
          got = respQ.pop_front();
          if (respDest !== got.dest) reportMismatch("respDest", 64'(got.dest), 64'(respDest));
          if (respData !== got.word) reportMismatch("respData", 64'(got.word), 64'(respData));
        end
      end

      if (uInstValid && uInstReady) begin
        rd = 1'b0;
        wr = 1'b0;
        fe = 1'b0;
        case (memFunc)
          memFuncPkg::AREAD: begin
            case (dispatch)
              3'd1: begin
                rd = 1'b1;
                fe = 1'b1;
              end
              3'd3: wr = 1'b1;
              3'd4, 3'd5: rd = 1'b1;
              3'd6, 3'd7: begin
                rd = 1'b1;
                wr = 1'b1;
              end
              default: ;
            endcase
          end
          memFuncPkg::READ_AR, memFuncPkg::READ_ARX: rd = 1'b1;
          memFuncPkg::WRITE: wr = 1'b1;
          memFuncPkg::RW_CYCLE, memFuncPkg::RPW_CYCLE: begin
            rd = 1'b1;
            wr = 1'b1;
          end
          memFuncPkg::UNCOND_FETCH: begin
            rd = 1'b1;
            fe = 1'b1;
          end
          default: ;
        endcase
        if (fe) dest = memFuncPkg::DEST_IR;
        else if (memFunc == memFuncPkg::READ_ARX) dest = memFuncPkg::DEST_ARX;
        else dest = memFuncPkg::DEST_AR;
        // Previous context never applies to fetches
        usePrev = prevEnable & ~fe;
        sect = usePrev ? prevSection : vmaSection;
        if (rd || wr) begin
          statusModel = {usePrev ? prevUser : userMode, publicMode, usePrev,
                         fmExtended & (|sect), rd, wr, fe, stepExpErr};
          errNext = stepExpErr;
          if (!stepExpErr) begin
            if (rd) respQ.push_back('{dest: dest, word: refMem[vmaOffset[ADDR_WIDTH-1:0]]});
            if (wr) refMem[vmaOffset[ADDR_WIDTH-1:0]] = writeData;
          end
        end
      end
    end
    pendingCount = respQ.size();
  end

endmodule

`default_nettype wire

/* verif/memSubsystemTb.sv */
`timescale 1ns/100ps
`default_nettype none

module memSubsystemTb;

  localparam logic [1:0] MICRO = 2'd0;
  localparam logic [1:0] DWRITE = 2'd1;
  localparam logic [1:0] DREAD = 2'd2;
  localparam logic [1:0] OKAY = diagPkg::RESP_OKAY;
  localparam logic [1:0] SLVERR = diagPkg::RESP_SLVERR;
  // Context bits as {userMode, publicMode, prevEnable, prevUser, fmExtended}
  localparam logic [4:0] CTX_PLAIN = 5'b01000;
  localparam logic [4:0] CTX_PREV = 5'b00110;
  localparam logic [4:0] CTX_EXT = 5'b10001;

  typedef struct packed {
    logic [1:0] kind;
    memFuncPkg::memFuncT func;
    memFuncPkg::dispatchT disp;
    logic [31:0] addr;
    logic [4:0] section;
    logic [4:0] ctx;
    logic [4:0] prevSect;
    logic expErr;
    logic [1:0] expResp;
    logic [3:0] holdR;
  } stepT;

  logic clk, reset, uInstValid, uInstReady;
  memFuncPkg::memFuncT memFunc;
  memFuncPkg::dispatchT dispatch;
  logic [35:0] writeData, respData, word;
  logic [4:0] vmaSection, prevSection;
  logic [17:0] vmaOffset;
  logic userMode, publicMode, prevEnable, prevUser, fmExtended, respValid, adrErr;
  memFuncPkg::destT respDest;
  logic AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
  logic ARVALID, ARREADY, RVALID, RREADY, stepExpErr, seen;
  logic [31:0] AWADDR, ARADDR, lfsr;
  logic [63:0] WDATA, RDATA;
  logic [1:0] BRESP, RRESP, stepExpResp;
  int errorCount, pendingCount;
  int cycleCount = 0;
  int cycleLimit = 100000;
  stepT steps[$];
  stepT s;

  memSubsystem UUT (.*);
  memChecker monitor (.*);

  function automatic stepT makeMicroStep(input memFuncPkg::memFuncT f,
      input memFuncPkg::dispatchT d, input logic [17:0] off, input logic [4:0] sect,
      input logic [4:0] ctx, input logic [4:0] ps, input logic err);
    stepT r;
    r = '0;
    r.kind = MICRO;
    r.func = f;
    r.disp = d;
    r.addr = {14'd0, off};
    r.section = sect;
    r.ctx = ctx;
    r.prevSect = ps;
    r.expErr = err;
    return r;
  endfunction

  function automatic stepT makeDiagStep(input logic [1:0] kind, input logic [31:0] addr,
      input logic [1:0] resp, input logic [3:0] hold);
    stepT r;
    r = '0;
    r.kind = kind;
    r.func = memFuncPkg::NOP;
    r.addr = addr;
    r.expResp = resp;
    r.holdR = hold;
    return r;
  endfunction

  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per data bit
  task automatic drawWord(output logic [35:0] w);
    w = '0;
    for (int i = 0; i < 36; i++) begin
      w = {w[34:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run exceeded %0d cycles", cycleLimit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    {reset, uInstValid, AWVALID, WVALID, ARVALID, RREADY, stepExpErr} = 7'b1000000;
    BREADY = 1'b1;
    memFunc = memFuncPkg::NOP;
    {dispatch, writeData, vmaSection, prevSection, vmaOffset} = '0;
    {userMode, publicMode, prevEnable, prevUser, fmExtended} = '0;
    {AWADDR, ARADDR, WDATA, stepExpResp} = '0;
    lfsr = 32'hc5ae;

    // Diag write then three reads of word 5
    steps.push_back(makeDiagStep(DWRITE, 32'h28, OKAY, 4'd0));
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd5, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::READ_ARX, 3'd0, 18'd5, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::UNCOND_FETCH, 3'd0, 18'd5, 5'd0, CTX_PREV, 5'd3, 1'b0));
    // AREAD dispatch sweep over words 8 and 9
    steps.push_back(makeDiagStep(DWRITE, 32'h40, OKAY, 4'd0));
    for (int d = 0; d < 8; d++) begin
      steps.push_back(makeMicroStep(memFuncPkg::AREAD, 3'(d), (d == 5 || d < 3) ? 18'd8 : 18'd9,
                                    5'd0, CTX_PLAIN, 5'd0, 1'b0));
    end
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd9, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    // Address errors and previous context
    steps.push_back(makeDiagStep(DWRITE, 32'h60, OKAY, 4'd0));
    steps.push_back(makeMicroStep(memFuncPkg::WRITE, 3'd0, 18'd12, 5'd3, CTX_PLAIN, 5'd0, 1'b1));
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd12, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd12, 5'd0, CTX_PREV, 5'd2, 1'b1));
    steps.push_back(makeDiagStep(DREAD, diagPkg::STATUS_ADDR, OKAY, 4'd0));
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd12, 5'd7, CTX_PREV, 5'd0, 1'b0));
    steps.push_back(makeDiagStep(DREAD, diagPkg::STATUS_ADDR, OKAY, 4'd0));
    steps.push_back(makeMicroStep(memFuncPkg::WRITE, 3'd0, 18'd13, 5'd4, CTX_EXT, 5'd0, 1'b0));
    steps.push_back(makeDiagStep(DREAD, diagPkg::STATUS_ADDR, OKAY, 4'd0));
    steps.push_back(makeDiagStep(DREAD, 32'h68, OKAY, 4'd0));
    steps.push_back(makeDiagStep(DREAD, 32'h2000, SLVERR, 4'd0));
    steps.push_back(makeDiagStep(DWRITE, 32'h4000, SLVERR, 4'd0));
    // Mixed traffic with a stalled read channel
    steps.push_back(makeMicroStep(memFuncPkg::WRITE, 3'd0, 18'd20, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeDiagStep(DWRITE, 32'hF0, OKAY, 4'd0));
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd20, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::RW_CYCLE, 3'd0, 18'd20, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeDiagStep(DREAD, 32'hF0, OKAY, 4'd6));
    steps.push_back(makeMicroStep(memFuncPkg::UNCOND_FETCH, 3'd0, 18'd20, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::READ_ARX, 3'd0, 18'd20, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::WRITE, 3'd0, 18'd21, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeMicroStep(memFuncPkg::RPW_CYCLE, 3'd0, 18'd21, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    steps.push_back(makeDiagStep(DREAD, 32'h28, OKAY, 4'd3));
    steps.push_back(makeMicroStep(memFuncPkg::READ_AR, 3'd0, 18'd21, 5'd0, CTX_PLAIN, 5'd0, 1'b0));
    cycleLimit = 40 * steps.size();

    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    foreach (steps[i]) begin
      s = steps[i];
      drawWord(word);
      stepExpErr = s.expErr;
      stepExpResp = s.expResp;
      if (s.kind == MICRO) begin
        {userMode, publicMode, prevEnable, prevUser, fmExtended} = s.ctx;
        memFunc = s.func;
        dispatch = s.disp;
        vmaOffset = s.addr[17:0];
        vmaSection = s.section;
        prevSection = s.prevSect;
        writeData = word;
        uInstValid = 1'b1;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk) seen = uInstReady;
          @(posedge clk);
        end
        #1 uInstValid = 1'b0;
      end else if (s.kind == DWRITE) begin
        AWADDR = s.addr;
        WDATA = {28'd0, word};
        {AWVALID, WVALID} = 2'b11;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk) seen = AWREADY;
          @(posedge clk);
        end
        #1 {AWVALID, WVALID} = 2'b00;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk) seen = BVALID;
          @(posedge clk);
        end
        #1;
      end else begin
        ARADDR = s.addr;
        ARVALID = 1'b1;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk) seen = ARREADY;
          @(posedge clk);
        end
        #1 ARVALID = 1'b0;
        repeat (s.holdR) @(posedge clk);
        if (s.holdR != 0) #1;
        RREADY = 1'b1;
        seen = 1'b0;
        while (!seen) begin
          @(negedge clk) seen = RVALID;
          @(posedge clk);
        end
        #1 RREADY = 1'b0;
      end
    end

    while (pendingCount != 0) @(posedge clk);
    repeat (5) @(posedge clk);
    $display("Errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
common/memFuncPkg.sv
common/diagPkg.sv
mcl/memControl.sv
mcl/vmaContext.sv
src/reqQueue.sv
src/cycleArbiter.sv
src/coreMemory.sv
src/diagAxiPort.sv
src/memSubsystem.sv
verif/memChecker.sv
verif/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module memSubsystemTb -f flist.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
